//--- vlog.f
simf_isa_pkg.sv
simf_fp_pkg.sv
alu_decode.sv
src_modifier.sv
cmp_unit.sv
fmul_seq.sv
alu_ctrl.sv
fpalu_top.sv
fpalu_chk.sv
fpalu_check.sv
fpalu_tb.sv

//--- run.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fpalu_tb \
   -f vlog.f -Mdir obj_dir -o fpalu_sim

./obj_dir/fpalu_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
exit 0

//--- fpalu_tb.sv
`timescale 1ns/100ps

module fpalu_tb;

   logic                     clk;
   logic                     rst_i;
   logic                     start_i;
   simf_isa_pkg::ctrl_word_t ctrl_i;
   simf_fp_pkg::word_t       src1_i;
   simf_fp_pkg::word_t       src2_i;
   logic                     vcc_i;
   logic                     exec_i;
   logic                     busy_o;
   logic                     done_o;
   simf_fp_pkg::word_t       dest_data_o;
   logic                     vcc_o;

   string test_name;            // Read by the checker at acceptance
   int    issued;
   int    timeouts;
   int    protocol_errs;
   int    total;
   simf_fp_pkg::word_t x;
   simf_isa_pkg::ctrl_word_t c;

   fpalu_top dut0
     (
      .clk (clk), .rst_i (rst_i), .start_i (start_i), .ctrl_i (ctrl_i),
      .src1_i (src1_i), .src2_i (src2_i), .vcc_i (vcc_i), .exec_i (exec_i),
      .busy_o (busy_o), .done_o (done_o), .dest_data_o (dest_data_o), .vcc_o (vcc_o)
     );

   fpalu_check chk0
     (
      .clk (clk), .rst_i (rst_i), .start_i (start_i), .ctrl_i (ctrl_i),
      .src1_i (src1_i), .src2_i (src2_i), .vcc_i (vcc_i), .exec_i (exec_i),
      .busy_o (busy_o), .done_o (done_o), .dest_data_o (dest_data_o), .vcc_o (vcc_o)
     );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic simf_isa_pkg::ctrl_word_t make_ctrl(input simf_isa_pkg::fmt_t fmt,
                                                          input simf_isa_pkg::opcode_t opc,
                                                          input logic [1:0] abs_m,
                                                          input logic [1:0] neg_m);
      simf_isa_pkg::ctrl_word_t w;
      w = '0;
      w[31:24] = fmt;
      w[11:0]  = opc;
      w[simf_isa_pkg::ABS1_POS] = abs_m[0];
      w[simf_isa_pkg::ABS2_POS] = abs_m[1];
      w[simf_isa_pkg::NEG1_POS] = neg_m[0];
      w[simf_isa_pkg::NEG2_POS] = neg_m[1];
      return w;
   endfunction

   // Random normal number with exponent inside lo..hi
   function automatic simf_fp_pkg::word_t rand_normal(input int lo, input int hi);
      simf_fp_pkg::word_t w;
      int e;
      e = lo + int'($urandom % (hi - lo + 1));
      w = $urandom;
      w[30:23] = e[7:0];
      return w;
   endfunction

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy_o && n < 100)
      begin
         @(negedge clk);
         n++;
      end
      if (busy_o)
      begin
         $display("timeout: busy_o stayed high in %s", test_name);
         timeouts++;
      end
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (!done_o && n < 100)
      begin
         @(negedge clk);
         n++;
      end
      if (!done_o)
      begin
         $display("timeout: done_o never arrived in %s", test_name);
         timeouts++;
      end
   endtask

   task automatic issue(input string name, input simf_isa_pkg::ctrl_word_t ctrl,
                        input simf_fp_pkg::word_t a, input simf_fp_pkg::word_t b,
                        input logic vcc, input logic exec);
      wait_idle();
      test_name = name;
      start_i   = 1'b1;
      ctrl_i    = ctrl;
      src1_i    = a;
      src2_i    = b;
      vcc_i     = vcc;
      exec_i    = exec;
      @(negedge clk);
      start_i = 1'b0;
      ctrl_i  = $urandom;  // Inputs only matter at acceptance
      src1_i  = $urandom;
      src2_i  = $urandom;
      vcc_i   = 1'($urandom);
      exec_i  = 1'($urandom);
      issued++;
      wait_done();
      @(negedge clk);
   endtask

   initial
   begin
      void'($urandom(32'h6524));
      rst_i   = 1'b1;
      start_i = 1'b0;
      ctrl_i  = '0;
      src1_i  = '0;
      src2_i  = '0;
      vcc_i   = 1'b0;
      exec_i  = 1'b0;
      issued        = 0;
      timeouts      = 0;
      protocol_errs = 0;
      test_name     = "reset";
      repeat (10) @(negedge clk);
      rst_i = 1'b0;
      @(negedge clk);

      for (int p = 0; p < 16; p++)
      begin
         c = make_ctrl(simf_isa_pkg::FMT_VOPC, 12'(p), 2'b00, 2'b00);
         issue("vopc_rand", c, $urandom, $urandom, 1'($urandom), 1'b1);
         x = $urandom;
         issue("vopc_equal", c, x, x, 1'($urandom), 1'b1);
      end

      for (int i = 0; i < 20; i++)
      begin
         c = make_ctrl(simf_isa_pkg::FMT_VOP3A, 12'($urandom % 16), 2'($urandom), 2'($urandom));
         issue("vop3a_cmp", c, $urandom, $urandom, 1'($urandom), 1'b1);
         c = make_ctrl(simf_isa_pkg::FMT_VOP3A, simf_isa_pkg::OPC_MUL_VOP3A,
                       2'($urandom), 2'($urandom));
         issue("vop3a_mul", c, rand_normal(64, 190), rand_normal(64, 190), 1'($urandom), 1'b1);
      end

      for (int i = 0; i < 20; i++)
      begin
         c = make_ctrl(simf_isa_pkg::FMT_VOP2, simf_isa_pkg::OPC_MAX_VOP2, 2'b00, 2'b00);
         issue("vop2_max", c, $urandom, $urandom, 1'($urandom), 1'b1);
         c = make_ctrl(simf_isa_pkg::FMT_VOP2, simf_isa_pkg::OPC_MUL_VOP2, 2'b00, 2'b00);
         issue("vop2_mul", c, rand_normal(1, 254), rand_normal(1, 254), 1'($urandom), 1'b1);
         issue("mul_overflow", c, rand_normal(200, 254), rand_normal(190, 254), 1'($urandom), 1'b1);
         issue("mul_underflow", c, rand_normal(1, 40), rand_normal(1, 60), 1'($urandom), 1'b1);
         x = rand_normal(1, 254);
         x[30:23] = 8'd0;
         issue("mul_zero_exp", c, x, rand_normal(1, 254), 1'($urandom), 1'b1);
      end

      c = make_ctrl(simf_isa_pkg::FMT_VOP2, simf_isa_pkg::OPC_MUL_VOP2, 2'b00, 2'b00);
      issue("exec_off_mul", c, rand_normal(1, 254), rand_normal(1, 254), 1'b1, 1'b0);
      c = make_ctrl(simf_isa_pkg::FMT_VOP2, simf_isa_pkg::OPC_MAX_VOP2, 2'b00, 2'b00);
      issue("exec_off_max", c, $urandom, $urandom, 1'b0, 1'b0);
      c = make_ctrl(simf_isa_pkg::FMT_VOPC, 12'h00F, 2'b00, 2'b00);
      issue("exec_off_cmp", c, $urandom, $urandom, 1'b0, 1'b0);
      issue("bad_fmt", make_ctrl(8'h01, 12'h008, 2'b00, 2'b00), $urandom, $urandom, 1'b1, 1'b1);
      issue("bad_vop2_opc", make_ctrl(simf_isa_pkg::FMT_VOP2, 12'h020, 2'b00, 2'b00),
            $urandom, $urandom, 1'b1, 1'b1);
      issue("bad_vop3a_opc", make_ctrl(simf_isa_pkg::FMT_VOP3A, 12'h200, 2'b00, 2'b00),
            $urandom, $urandom, 1'b0, 1'b1);

      // Second start arrives mid multiply and must be dropped
      wait_idle();
      test_name = "busy_ignore";
      c = make_ctrl(simf_isa_pkg::FMT_VOP2, simf_isa_pkg::OPC_MUL_VOP2, 2'b00, 2'b00);
      start_i = 1'b1;
      ctrl_i  = c;
      src1_i  = rand_normal(100, 150);
      src2_i  = rand_normal(100, 150);
      vcc_i   = 1'b1;
      exec_i  = 1'b1;
      @(negedge clk);
      start_i = 1'b0;
      issued++;
      repeat (5) @(negedge clk);
      start_i = 1'b1;
      ctrl_i  = make_ctrl(simf_isa_pkg::FMT_VOPC, 12'h00F, 2'b00, 2'b00);
      vcc_i   = 1'b0;
      @(negedge clk);
      start_i = 1'b0;
      wait_done();
      repeat (40) @(negedge clk);

      if (chk0.done_count != issued)
      begin
         $display("completion count wrong: %0d instructions accepted, %0d completions seen",
                  issued, chk0.done_count);
         protocol_errs++;
      end
      total = chk0.err_count + timeouts + protocol_errs;
      $display("errors: mismatch=%0d timeout=%0d protocol=%0d total=%0d",
               chk0.err_count, timeouts, protocol_errs, total);
      if (total == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- fpalu_check.sv
`timescale 1ns/100ps

module fpalu_check
  (
   input logic                     clk,
   input logic                     rst_i,
   input logic                     start_i,
   input simf_isa_pkg::ctrl_word_t ctrl_i,
   input simf_fp_pkg::word_t       src1_i,
   input simf_fp_pkg::word_t       src2_i,
   input logic                     vcc_i,
   input logic                     exec_i,
   input logic                     busy_o,
   input logic                     done_o,
   input simf_fp_pkg::word_t       dest_data_o,
   input logic                     vcc_o
  );

   int    err_count = 0;
   int    done_count = 0;
   logic  acc_q = 1'b0;
   logic [32:0] exp_q[$];
   string name_q[$];

   function automatic simf_fp_pkg::word_t modify(input simf_fp_pkg::word_t v,
                                                 input logic a, input logic n);
      simf_fp_pkg::word_t r;
      r = (a && v[simf_fp_pkg::SIGN_POS]) ? -v : v;
      return n ? -r : r;
   endfunction

   function automatic logic predicate(input logic [3:0] p, input simf_fp_pkg::word_t a,
                                      input simf_fp_pkg::word_t b);
      case (p)
         4'd1, 4'd9:   return a < b;
         4'd2, 4'd10:  return a == b;
         4'd3, 4'd12:  return (p == 4'd3) ? (a <= b) : !(a <= b);
         4'd4, 4'd11:  return (p == 4'd4) ? (a > b) : !(a > b);
         4'd5, 4'd13:  return a != b;
         4'd6, 4'd14:  return a >= b;
         4'd15:        return 1'b1;
         default:      return 1'b0;
      endcase
   endfunction

   function automatic simf_fp_pkg::word_t mul_ref(input simf_fp_pkg::word_t a,
                                                  input simf_fp_pkg::word_t b);
      simf_fp_pkg::prod_t p;
      logic s;
      int e;
      s = a[31] ^ b[31];
      if (a[30:23] == 8'd0 || b[30:23] == 8'd0)
         return {s, 31'd0};
      p = simf_fp_pkg::prod_t'({1'b1, a[22:0]}) * simf_fp_pkg::prod_t'({1'b1, b[22:0]});
      e = int'(a[30:23]) + int'(b[30:23]) - simf_fp_pkg::EXP_BIAS + int'(p[47]);
      if (e <= 0)
         return {s, 31'd0};
      if (e >= simf_fp_pkg::EXP_MAX)
         return {s, 8'hFF, 23'd0};
      return p[47] ? {s, e[7:0], p[46:24]} : {s, e[7:0], p[45:23]};
   endfunction

   // Expected {vcc_o, dest_data_o}
   function automatic logic [32:0] expected(input simf_isa_pkg::ctrl_word_t c,
                                            input simf_fp_pkg::word_t s1,
                                            input simf_fp_pkg::word_t s2,
                                            input logic vcc, input logic exec);
      simf_isa_pkg::fmt_t f;
      simf_isa_pkg::opcode_t o;
      simf_fp_pkg::word_t a;
      simf_fp_pkg::word_t b;
      f = c[31:24];
      o = c[11:0];
      a = s1;
      b = s2;
      if (f == simf_isa_pkg::FMT_VOP3A)
      begin
         a = modify(s1, c[simf_isa_pkg::ABS1_POS], c[simf_isa_pkg::NEG1_POS]);
         b = modify(s2, c[simf_isa_pkg::ABS2_POS], c[simf_isa_pkg::NEG2_POS]);
      end
      if (!exec)
         return {vcc, 32'd0};
      if ((f == simf_isa_pkg::FMT_VOPC || f == simf_isa_pkg::FMT_VOP3A) && o[11:4] == 8'd0)
         return {predicate(o[3:0], a, b), 32'd0};
      if ((f == simf_isa_pkg::FMT_VOP2 && o == simf_isa_pkg::OPC_MUL_VOP2) ||
          (f == simf_isa_pkg::FMT_VOP3A && o == simf_isa_pkg::OPC_MUL_VOP3A))
         return {vcc, mul_ref(a, b)};
      if (f == simf_isa_pkg::FMT_VOP2 && o == simf_isa_pkg::OPC_MAX_VOP2)
         return {vcc, (a > b) ? a : b};
      return {vcc, 32'd0};
   endfunction

   always @(posedge clk)
   begin
      if (!rst_i && acc_q && !busy_o)
      begin
         $display("busy_o stayed low in the cycle after an accepted instruction");
         err_count++;
      end
      if (!rst_i && done_o && busy_o)
      begin
         $display("busy_o was high while done_o was high");
         err_count++;
      end
      acc_q <= !rst_i && start_i && !busy_o;
      if (!rst_i && start_i && !busy_o)
      begin
         exp_q.push_back(expected(ctrl_i, src1_i, src2_i, vcc_i, exec_i));
         name_q.push_back(fpalu_tb.test_name);
      end
      if (!rst_i && done_o)
      begin
         done_count++;
         if (exp_q.size() == 0)
         begin
            $display("done_o pulsed with no accepted instruction waiting");
            err_count++;
         end
         else
         begin
            logic [32:0] e;
            string n;
            e = exp_q.pop_front();
            n = name_q.pop_front();
            if (dest_data_o !== e[31:0])
            begin
               $display("mismatch %s dest_data expected %h actual %h", n, e[31:0], dest_data_o);
               err_count++;
            end
            if (vcc_o !== e[32])
            begin
               $display("mismatch %s vcc expected %b actual %b", n, e[32], vcc_o);
               err_count++;
            end
         end
      end
   end

endmodule

//--- fpalu_chk.sv
`timescale 1ns/100ps

module fpalu_chk
  (
   input logic                  clk,
   input logic                  rst_i,
   input logic                  start_i,
   input logic                  exec_i,
   input logic                  busy_o,
   input logic                  done_o,
   input simf_isa_pkg::alu_op_e dec_op
  );

   logic pending;
   logic accept;

   assign accept = start_i && !busy_o;

   always_ff @(posedge clk)
   begin
      if (rst_i)
         pending <= 1'b0;
      else if (accept)
         pending <= 1'b1;
      else if (done_o)
         pending <= 1'b0;
   end

   done_single: assert property (@(posedge clk) disable iff (rst_i) done_o |=> !done_o)
      else $error("done_o high for two cycles");

   done_after_accept: assert property (@(posedge clk) disable iff (rst_i)
                                       $rose(done_o) |-> pending)
      else $error("done_o without acceptance");

   idle_after_reset: assert property (@(posedge clk) rst_i |=> !busy_o)
      else $error("busy_o high after reset");

   // Done is high in the 26th cycle after the accepting edge
   mul_latency: assert property (@(posedge clk) disable iff (rst_i)
                                 (accept && exec_i && dec_op == simf_isa_pkg::OP_MUL)
                                 |=> ##25 !done_o ##1 done_o)
      else $error("multiply latency wrong");

endmodule

bind fpalu_top fpalu_chk chk_b
  (
   .clk     (clk),
   .rst_i   (rst_i),
   .start_i (start_i),
   .exec_i  (exec_i),
   .busy_o  (busy_o),
   .done_o  (done_o),
   .dec_op  (dec_op)
  );

//--- fpalu_top.sv
`timescale 1ns/100ps

module fpalu_top
  (
   input  logic                     clk,
   input  logic                     rst_i,
   input  logic                     start_i,
   input  simf_isa_pkg::ctrl_word_t ctrl_i,
   input  simf_fp_pkg::word_t       src1_i,
   input  simf_fp_pkg::word_t       src2_i,
   input  logic                     vcc_i,
   input  logic                     exec_i,
   output logic                     busy_o,
   output logic                     done_o,
   output simf_fp_pkg::word_t       dest_data_o,
   output logic                     vcc_o
  );

   simf_isa_pkg::alu_op_e   dec_op;
   simf_isa_pkg::cmp_pred_t dec_pred;
   logic [1:0]              dec_abs;
   logic [1:0]              dec_neg;
   simf_fp_pkg::word_t      mod_src1;
   simf_fp_pkg::word_t      mod_src2;
   simf_fp_pkg::word_t      opa;
   simf_fp_pkg::word_t      opb;
   simf_isa_pkg::cmp_pred_t cap_pred;
   logic                    cmp_res;
   simf_fp_pkg::word_t      max_res;
   logic                    mul_start;
   simf_fp_pkg::word_t      mul_product;
   logic                    mul_valid;

   alu_decode u_decode
     (
      .ctrl_i (ctrl_i),
      .op_o   (dec_op),
      .pred_o (dec_pred),
      .abs_o  (dec_abs),
      .neg_o  (dec_neg)
     );

   src_modifier u_modifier
     (
      .src1_i (src1_i),
      .src2_i (src2_i),
      .abs_i  (dec_abs),
      .neg_i  (dec_neg),
      .src1_o (mod_src1),
      .src2_o (mod_src2)
     );

   alu_ctrl u_ctrl
     (
      .clk             (clk),
      .rst_i           (rst_i),
      .start_i         (start_i),
      .op_i            (dec_op),
      .pred_i          (dec_pred),
      .src1_i          (mod_src1),
      .src2_i          (mod_src2),
      .vcc_i           (vcc_i),
      .exec_i          (exec_i),
      .cmp_i           (cmp_res),
      .max_i           (max_res),
      .product_i       (mul_product),
      .product_valid_i (mul_valid),
      .opa_o           (opa),
      .opb_o           (opb),
      .pred_o          (cap_pred),
      .mul_start_o     (mul_start),
      .busy_o          (busy_o),
      .done_o          (done_o),
      .dest_data_o     (dest_data_o),
      .vcc_o           (vcc_o)
     );

   cmp_unit u_cmp
     (
      .a_i    (opa),
      .b_i    (opb),
      .pred_i (cap_pred),
      .cmp_o  (cmp_res),
      .max_o  (max_res)
     );

   fmul_seq u_fmul
     (
      .clk             (clk),
      .rst_i           (rst_i),
      .start_i         (mul_start),
      .a_i             (opa),
      .b_i             (opb),
      .product_o       (mul_product),
      .product_valid_o (mul_valid)
     );

endmodule

//--- alu_ctrl.sv
`timescale 1ns/100ps

module alu_ctrl
  (
   input  logic                    clk,
   input  logic                    rst_i,
   input  logic                    start_i,
   input  simf_isa_pkg::alu_op_e   op_i,
   input  simf_isa_pkg::cmp_pred_t pred_i,
   input  simf_fp_pkg::word_t      src1_i,
   input  simf_fp_pkg::word_t      src2_i,
   input  logic                    vcc_i,
   input  logic                    exec_i,
   input  logic                    cmp_i,
   input  simf_fp_pkg::word_t      max_i,
   input  simf_fp_pkg::word_t      product_i,
   input  logic                    product_valid_i,
   output simf_fp_pkg::word_t      opa_o,
   output simf_fp_pkg::word_t      opb_o,
   output simf_isa_pkg::cmp_pred_t pred_o,
   output logic                    mul_start_o,
   output logic                    busy_o,
   output logic                    done_o,
   output simf_fp_pkg::word_t      dest_data_o,
   output logic                    vcc_o
  );

   typedef enum logic [1:0] {CS_IDLE, CS_ONE, CS_MUL} ctrl_state_e;

   ctrl_state_e             state_q;
   simf_isa_pkg::alu_op_e   op_q;
   simf_isa_pkg::cmp_pred_t pred_q;
   simf_fp_pkg::word_t      opa_q;
   simf_fp_pkg::word_t      opb_q;
   logic                    vcc_q;
   logic                    exec_q;
   logic                    accept;

   assign accept = start_i && (state_q == CS_IDLE);
   assign busy_o = (state_q != CS_IDLE);
   assign opa_o  = opa_q;
   assign opb_o  = opb_q;
   assign pred_o = pred_q;

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         op_q   <= op_i;
         pred_q <= pred_i;
         opa_q  <= src1_i;  // Modifiers already applied
         opb_q  <= src2_i;
         vcc_q  <= vcc_i;
         exec_q <= exec_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         state_q     <= CS_IDLE;
         mul_start_o <= 1'b0;
         done_o      <= 1'b0;
         dest_data_o <= '0;
         vcc_o       <= 1'b0;
      end
      else
      begin
         mul_start_o <= 1'b0;
         done_o      <= 1'b0;
         case (state_q)
            CS_IDLE:
            begin
               if (accept)
               begin
                  if (exec_i && op_i == simf_isa_pkg::OP_MUL)
                  begin
                     state_q     <= CS_MUL;
                     mul_start_o <= 1'b1;  // Launch cycle
                  end
                  else
                     state_q <= CS_ONE;
               end
            end
            CS_ONE:
            begin
               state_q     <= CS_IDLE;
               done_o      <= 1'b1;
               dest_data_o <= '0;
               vcc_o       <= vcc_q;
               if (exec_q)
               begin
                  case (op_q)
                     simf_isa_pkg::OP_CMP: vcc_o       <= cmp_i;
                     simf_isa_pkg::OP_MAX: dest_data_o <= max_i;
                     default:              dest_data_o <= '0;
                  endcase
               end
            end
            CS_MUL:
            begin
               if (product_valid_i)
               begin
                  state_q     <= CS_IDLE;
                  done_o      <= 1'b1;
                  dest_data_o <= product_i;
                  vcc_o       <= vcc_q;
               end
            end
            default:
               state_q <= CS_IDLE;
         endcase
      end
   end

endmodule

//--- fmul_seq.sv
`timescale 1ns/100ps

module fmul_seq
  (
   input  logic               clk,
   input  logic               rst_i,
   input  logic               start_i,
   input  simf_fp_pkg::word_t a_i,
   input  simf_fp_pkg::word_t b_i,
   output simf_fp_pkg::word_t product_o,
   output logic               product_valid_o
  );

   typedef enum logic {MS_IDLE, MS_RUN} mul_state_e;

   mul_state_e          state_q;
   logic [4:0]          step_q;
   simf_fp_pkg::mant_t  mcand_q;
   simf_fp_pkg::prod_t  prod_q;
   logic                sign_q;
   logic                zero_q;
   logic signed [9:0]   exp_sum_q;
   simf_fp_pkg::exp_t   exp_a;
   simf_fp_pkg::exp_t   exp_b;
   logic [24:0]         part_sum;
   simf_fp_pkg::prod_t  prod_next;
   logic signed [9:0]   exp_fin;
   simf_fp_pkg::word_t  result;

   assign exp_a = a_i[30:23];
   assign exp_b = b_i[30:23];

   // Multiplier sits in the low half and shifts out as partial sums shift in
   assign part_sum  = {1'b0, prod_q[47:24]} + (prod_q[0] ? {1'b0, mcand_q} : 25'd0);
   assign prod_next = {part_sum, prod_q[23:1]};
   assign exp_fin   = exp_sum_q + 10'(prod_next[47]);

   always_comb
   begin
      if (zero_q || exp_fin <= 10'sd0)
         result = {sign_q, 31'd0};                                   // Zero or underflow
      else if (exp_fin >= $signed(10'(simf_fp_pkg::EXP_MAX)))
         result = {sign_q, simf_fp_pkg::exp_t'(simf_fp_pkg::EXP_MAX), 23'd0};
      else if (prod_next[47])
         result = {sign_q, exp_fin[7:0], prod_next[46:24]};
      else
         result = {sign_q, exp_fin[7:0], prod_next[45:23]};
   end

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         state_q         <= MS_IDLE;
         step_q          <= 5'd0;
         product_o       <= '0;
         product_valid_o <= 1'b0;
      end
      else
      begin
         product_valid_o <= 1'b0;
         case (state_q)
            MS_IDLE:
            begin
               if (start_i)
               begin
                  state_q <= MS_RUN;
                  step_q  <= 5'd0;
               end
            end
            MS_RUN:
            begin
               step_q <= step_q + 5'd1;
               if (step_q == 5'(simf_fp_pkg::MUL_STEPS - 1))
               begin
                  state_q         <= MS_IDLE;
                  product_o       <= result;  // Normalised on the last step
                  product_valid_o <= 1'b1;
               end
            end
            default:
               state_q <= MS_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == MS_IDLE && start_i)
      begin
         mcand_q   <= {1'b1, a_i[22:0]};
         prod_q    <= {24'd0, 1'b1, b_i[22:0]};
         sign_q    <= a_i[simf_fp_pkg::SIGN_POS] ^ b_i[simf_fp_pkg::SIGN_POS];
         zero_q    <= (exp_a == '0) || (exp_b == '0);
         exp_sum_q <= 10'(exp_a) + 10'(exp_b) - 10'(simf_fp_pkg::EXP_BIAS);
      end
      else if (state_q == MS_RUN)
         prod_q <= prod_next;
   end

endmodule

//--- cmp_unit.sv
`timescale 1ns/100ps

module cmp_unit
  (
   input  simf_fp_pkg::word_t      a_i,
   input  simf_fp_pkg::word_t      b_i,
   input  simf_isa_pkg::cmp_pred_t pred_i,
   output logic                    cmp_o,
   output simf_fp_pkg::word_t      max_o
  );

   logic lt;
   logic eq;
   logic gt;

   // Plain unsigned bit-pattern ordering
   assign lt = (a_i < b_i);
   assign eq = (a_i == b_i);
   assign gt = (a_i > b_i);

   assign max_o = (a_i >= b_i) ? a_i : b_i;

   always_comb
   begin
      case (pred_i)
         4'd1:    cmp_o = lt;
         4'd2:    cmp_o = eq;
         4'd3:    cmp_o = lt | eq;
         4'd4:    cmp_o = gt;
         4'd5:    cmp_o = ~eq;
         4'd6:    cmp_o = gt | eq;
         4'd9:    cmp_o = lt;       // Not ge
         4'd10:   cmp_o = eq;
         4'd11:   cmp_o = ~gt;
         4'd12:   cmp_o = gt;       // Not le
         4'd13:   cmp_o = ~eq;
         4'd14:   cmp_o = ~lt;
         4'd15:   cmp_o = 1'b1;
         default: cmp_o = 1'b0;     // F and the unordered codes 7 and 8
      endcase
   end

endmodule

//--- src_modifier.sv
`timescale 1ns/100ps

module src_modifier
  (
   input  simf_fp_pkg::word_t src1_i,
   input  simf_fp_pkg::word_t src2_i,
   input  logic [1:0]         abs_i,
   input  logic [1:0]         neg_i,
   output simf_fp_pkg::word_t src1_o,
   output simf_fp_pkg::word_t src2_o
  );

   // Integer abs then negate
   function automatic simf_fp_pkg::word_t apply_mod(input simf_fp_pkg::word_t v,
                                                    input logic use_abs,
                                                    input logic use_neg);
      simf_fp_pkg::word_t a;
      a = (use_abs && v[simf_fp_pkg::SIGN_POS]) ? (~v + 32'd1) : v;
      return use_neg ? (~a + 32'd1) : a;
   endfunction

   assign src1_o = apply_mod(src1_i, abs_i[0], neg_i[0]);
   assign src2_o = apply_mod(src2_i, abs_i[1], neg_i[1]);

endmodule

//--- alu_decode.sv
`timescale 1ns/100ps

module alu_decode
  (
   input  simf_isa_pkg::ctrl_word_t ctrl_i,
   output simf_isa_pkg::alu_op_e    op_o,
   output simf_isa_pkg::cmp_pred_t  pred_o,
   output logic [1:0]               abs_o,
   output logic [1:0]               neg_o
  );

   simf_isa_pkg::fmt_t    fmt;
   simf_isa_pkg::opcode_t opc;
   logic                  is_cmp_opc;

   assign fmt = ctrl_i[simf_isa_pkg::FMT_MSB:simf_isa_pkg::FMT_LSB];
   assign opc = ctrl_i[simf_isa_pkg::OPC_MSB:simf_isa_pkg::OPC_LSB];

   // Same compare numbering in VOPC and VOP3A
   assign is_cmp_opc = ((opc & simf_isa_pkg::OPC_CMP_MASK) == simf_isa_pkg::OPC_CMP_BASE_VOP3A);

   assign pred_o = opc[3:0];

   always_comb
   begin
      op_o  = simf_isa_pkg::OP_NOP;
      abs_o = 2'b00;
      neg_o = 2'b00;
      case (fmt)
         simf_isa_pkg::FMT_VOPC:
         begin
            if (is_cmp_opc)
               op_o = simf_isa_pkg::OP_CMP;
         end
         simf_isa_pkg::FMT_VOP2:
         begin
            if (opc == simf_isa_pkg::OPC_MUL_VOP2)
               op_o = simf_isa_pkg::OP_MUL;
            else if (opc == simf_isa_pkg::OPC_MAX_VOP2)
               op_o = simf_isa_pkg::OP_MAX;
         end
         simf_isa_pkg::FMT_VOP3A:
         begin
            abs_o = {ctrl_i[simf_isa_pkg::ABS2_POS], ctrl_i[simf_isa_pkg::ABS1_POS]};
            neg_o = {ctrl_i[simf_isa_pkg::NEG2_POS], ctrl_i[simf_isa_pkg::NEG1_POS]};
            if (is_cmp_opc)
               op_o = simf_isa_pkg::OP_CMP;
            else if (opc == simf_isa_pkg::OPC_MUL_VOP3A)
               op_o = simf_isa_pkg::OP_MUL;
         end
         default:
            op_o = simf_isa_pkg::OP_NOP; // Unsupported format
      endcase
   end

endmodule

//--- simf_fp_pkg.sv
package simf_fp_pkg;

   typedef logic [31:0] word_t;
   typedef logic [7:0]  exp_t;
   typedef logic [23:0] mant_t; // Includes hidden bit
   typedef logic [47:0] prod_t;

   localparam int EXP_BIAS  = 127;
   localparam int EXP_MAX   = 255;
   localparam int MUL_STEPS = 24; // One step per multiplier bit
   localparam int SIGN_POS  = 31;

endpackage

//--- simf_isa_pkg.sv
package simf_isa_pkg;

   typedef logic [31:0] ctrl_word_t;
   typedef logic [7:0]  fmt_t;
   typedef logic [11:0] opcode_t;
   typedef logic [3:0]  cmp_pred_t;

   localparam int FMT_MSB = 31;
   localparam int FMT_LSB = 24;
   localparam int OPC_MSB = 11;
   localparam int OPC_LSB = 0;

   // Format field values matched exactly
   localparam fmt_t FMT_VOP2  = 8'h02;
   localparam fmt_t FMT_VOPC  = 8'h04;
   localparam fmt_t FMT_VOP3A = 8'h08;

   // VOP3A source modifier bits
   localparam int ABS1_POS = 16;
   localparam int ABS2_POS = 17;
   localparam int NEG1_POS = 19;
   localparam int NEG2_POS = 20;

   localparam opcode_t OPC_CMP_BASE_VOP3A = 12'h000; // Compares occupy base..base+15
   localparam opcode_t OPC_CMP_MASK       = 12'hFF0;
   localparam opcode_t OPC_MUL_VOP2       = 12'h008;
   localparam opcode_t OPC_MAX_VOP2       = 12'h010;
   localparam opcode_t OPC_MUL_VOP3A      = 12'h108;

   typedef enum logic [1:0]
   {
      OP_NOP,
      OP_CMP,
      OP_MAX,
      OP_MUL
   } alu_op_e;

endpackage
